// ==== Makefile ====
TOP = dac_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Verification passed" run.log

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

// ==== hdl/dac_channel_bank.sv ====
`default_nettype none

module dac_channel_bank
   import dac_pkg::*;
(
   input  wire           DAC_CS,
   input  wire           rst,
   input  wire           clear,
   input  wire bank_op_t bank_op,
   output dac_codes_t    dac_codes
);

   // Input registers, staged codes not yet on the outputs
   code_t input_q [num_channels];
   // DAC registers, the codes that drive the converters
   dac_codes_t dac_q;

   always_ff @(posedge DAC_CS) begin
      if (rst || clear) begin
         // Clear pin zeroes the part the same way reset does
         for (int i = 0; i < num_channels; i++) begin
            input_q[i] <= '0;
         end
         dac_q <= '0;
      end else begin
         for (int i = 0; i < num_channels; i++) begin
            // Write goes to the input register
            if (bank_op.load_mask[i]) begin
               input_q[i] <= bank_op.code;
            end
            // Update takes the new code when written in the same frame
            if (bank_op.update_mask[i]) begin
               if (bank_op.load_mask[i]) begin
                  dac_q[i] <= bank_op.code;
               end else begin
                  dac_q[i] <= input_q[i];
               end
            end
         end
      end
   end

   assign dac_codes = dac_q;

endmodule

`default_nettype wire

// ==== hdl/dac_frame_ctrl.sv ====
`default_nettype none

module dac_frame_ctrl
   import dac_pkg::*;
(
   input  wire                   DAC_CS,
   input  wire                   rst,
   input  wire sampled_t         sampled,
   input  wire frame_t           frame,
   input  wire [count_bits-1:0]  bit_count,
   output bank_op_t              bank_op,
   output logic                  clear,
   output status_t               status,
   output logic                  status_valid
);

   // Set by a clear pulse, dropped only by reset
   logic armed;

   // Decode of the frame held in the shifter
   logic [num_channels-1:0] chan_mask;
   logic                    addr_ok;
   logic                    cmd_ok;
   logic                    do_load;
   logic                    do_update;
   frame_err_e              err_next;

   // Channel select from the address field
   always_comb begin
      chan_mask = '0;
      addr_ok   = 1'b0;
      if (frame.address == 4'b1111) begin
         // Broadcast to every channel
         chan_mask = '1;
         addr_ok   = 1'b1;
      end else if (frame.address < 4'(num_channels)) begin
         chan_mask = num_channels'(1) << frame.address;
         addr_ok   = 1'b1;
      end
   end

   // Command to load and update requests
   always_comb begin
      cmd_ok    = 1'b1;
      do_load   = 1'b0;
      do_update = 1'b0;
      case (frame.command)
         cmd_write: begin
            do_load = 1'b1;
         end
         cmd_update: begin
            do_update = 1'b1;
         end
         cmd_write_update: begin
            do_load   = 1'b1;
            do_update = 1'b1;
         end
         cmd_nop: begin
            // Accepted, touches nothing
         end
         default: begin
            cmd_ok = 1'b0;
         end
      endcase
   end

   // Error priority, first match wins
   always_comb begin
      if (!armed) begin
         err_next = err_not_armed;
      end else if (bit_count < count_bits'(frame_bits)) begin
         err_next = err_short;
      end else if (bit_count > count_bits'(frame_bits)) begin
         err_next = err_long;
      end else if (!cmd_ok) begin
         err_next = err_bad_cmd;
      end else if (!addr_ok) begin
         err_next = err_bad_addr;
      end else begin
         err_next = err_none;
      end
   end

   always_ff @(posedge DAC_CS) begin
      if (rst) begin
         armed        <= 1'b0;
         status_valid <= 1'b0;
         status       <= '0;
         bank_op      <= '0;
      end else begin
         // Masks and status only live for one cycle
         status_valid        <= 1'b0;
         bank_op.load_mask   <= '0;
         bank_op.update_mask <= '0;
         if (sampled.clr) begin
            armed <= 1'b1;
         end
         // Frame end, ignored while a clear is in progress
         if (sampled.sel_rise && !sampled.clr) begin
            status_valid   <= 1'b1;
            status.err     <= err_next;
            status.command <= frame.command;
            status.address <= frame.address;
            if (err_next == err_none) begin
               bank_op.load_mask   <= do_load ? chan_mask : '0;
               bank_op.update_mask <= do_update ? chan_mask : '0;
               bank_op.code        <= frame.value;
            end
         end
      end
   end

   // Bank clear follows the pin for as long as it is held
   assign clear = sampled.clr;

endmodule

`default_nettype wire

// ==== hdl/dac_pkg.sv ====
`default_nettype none

package dac_pkg;

   // Serial frame geometry
   localparam int frame_bits   = 32;
   localparam int code_bits    = 12;
   localparam int num_channels = 4;

   // Depth of the pin synchronizer
   localparam int sync_stages  = 2;

   // Bit counter range 0 to 33, the top value flags an overlong frame
   localparam int count_bits   = 6;

   // One 12-bit DAC code
   typedef logic [code_bits-1:0] code_t;

   // Command codes understood by the receiver
   typedef enum logic [3:0] {
      cmd_write        = 4'b0000,
      cmd_update       = 4'b0001,
      cmd_write_update = 4'b0011,
      cmd_nop          = 4'b1111
   } cmd_e;

   // Frame layout, MSB is the first bit on the wire
   typedef struct packed {
      logic [7:0] lead;
      logic [3:0] command;
      logic [3:0] address;
      code_t      value;
      logic [3:0] trail;
   } frame_t;

   // Raw serial pins as seen at the device
   typedef struct packed {
      logic sck;
      logic mosi;
      logic sel_n;
      logic clr_n;
   } pins_t;

   // Synchronized levels and single-cycle edge pulses
   typedef struct packed {
      logic mosi;
      logic sel;
      logic clr;
      logic sck_rise;
      logic sel_fall;
      logic sel_rise;
   } sampled_t;

   // Frame verdict, first failing check wins
   typedef enum logic [2:0] {
      err_none      = 3'd0,
      err_not_armed = 3'd1,
      err_short     = 3'd2,
      err_long      = 3'd3,
      err_bad_cmd   = 3'd4,
      err_bad_addr  = 3'd5
   } frame_err_e;

   // Result of one frame
   typedef struct packed {
      frame_err_e err;
      logic [3:0] command;
      logic [3:0] address;
   } status_t;

   // Register operation towards the channel bank
   typedef struct packed {
      logic [num_channels-1:0] load_mask;
      logic [num_channels-1:0] update_mask;
      code_t                   code;
   } bank_op_t;

   // Channel A sits in slot 0
   typedef code_t [num_channels-1:0] dac_codes_t;

endpackage

`default_nettype wire

// ==== hdl/dac_receiver_top.sv ====
`default_nettype none

module dac_receiver_top
   import dac_pkg::*;
(
   input  wire        DAC_CS,
   input  wire        rst,
   input  wire pins_t pins,
   output logic       sdo,
   output dac_codes_t dac_codes,
   output status_t    status,
   output logic       status_valid
);

   // Synchronized pins and edge pulses
   sampled_t sampled;
   // Received frame and its length
   frame_t frame;
   logic [count_bits-1:0] bit_count;
   // Register operation and clear towards the bank
   bank_op_t bank_op;
   logic clear;

   // Oversampling of the serial port
   pin_sampler u_pin_sampler (
      .DAC_CS  (DAC_CS),
      .rst     (rst),
      .pins    (pins),
      .sampled (sampled)
   );

   // Shift register and echo
   frame_shifter u_frame_shifter (
      .DAC_CS    (DAC_CS),
      .rst       (rst),
      .sampled   (sampled),
      .frame     (frame),
      .bit_count (bit_count),
      .sdo       (sdo)
   );

   // Arming, frame checks and decode
   dac_frame_ctrl u_dac_frame_ctrl (
      .DAC_CS       (DAC_CS),
      .rst          (rst),
      .sampled      (sampled),
      .frame        (frame),
      .bit_count    (bit_count),
      .bank_op      (bank_op),
      .clear        (clear),
      .status       (status),
      .status_valid (status_valid)
   );

   // Input and DAC registers
   dac_channel_bank u_dac_channel_bank (
      .DAC_CS    (DAC_CS),
      .rst       (rst),
      .clear     (clear),
      .bank_op   (bank_op),
      .dac_codes (dac_codes)
   );

endmodule

`default_nettype wire

// ==== hdl/frame_shifter.sv ====
`default_nettype none

module frame_shifter
   import dac_pkg::*;
(
   input  wire                   DAC_CS,
   input  wire                   rst,
   input  wire sampled_t         sampled,
   output frame_t                frame,
   output logic [count_bits-1:0] bit_count,
   output logic                  sdo
);

   // Receive register, also the echo source for the next frame
   frame_t shift_q;
   // Bits seen in the current frame
   logic [count_bits-1:0] count_q;
   // Serial clock edge that belongs to a selected frame
   logic shift_en;

   assign shift_en = sampled.sel && sampled.sck_rise && !sampled.sel_fall;

   // Bit counter
   always_ff @(posedge DAC_CS) begin
      if (rst) begin
         count_q <= '0;
      end else if (sampled.sel_fall) begin
         // New frame starts counting from zero
         count_q <= '0;
      end else if (shift_en) begin
         // Stop at 33, anything past 32 is just too long
         if (count_q != count_bits'(frame_bits + 1)) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   // Shift register
   // Old contents stay across frame start
   always_ff @(posedge DAC_CS) begin
      if (shift_en) begin
         // MSB first, new bit enters at the bottom
         shift_q <= frame_t'({shift_q[frame_bits-2:0], sampled.mosi});
      end
   end

   assign frame     = shift_q;
   assign bit_count = count_q;

   // Previous frame leaves MSB first while selected
   // Line idles low outside a frame
   assign sdo = sampled.sel ? shift_q[frame_bits-1] : 1'b0;

endmodule

`default_nettype wire

// ==== hdl/pin_sampler.sv ====
`default_nettype none

module pin_sampler
   import dac_pkg::*;
(
   input  wire      DAC_CS,
   input  wire      rst,
   input  wire      pins_t pins,
   output sampled_t sampled
);

   // Synchronizer chain, one pins_t per stage
   pins_t sync_q [sync_stages];
   // Output of the last stage
   pins_t pins_s;

   // Previous synchronized levels for edge detection
   logic sck_d;
   logic sel_n_d;

   // Registered edge pulses
   logic sck_rise_q;
   logic sel_fall_q;
   logic sel_rise_q;

   assign pins_s = sync_q[sync_stages-1];

   always_ff @(posedge DAC_CS) begin
      if (rst) begin
         // Frame select and clear start inactive, so no false edge
         for (int i = 0; i < sync_stages; i++) begin
            sync_q[i] <= '{sck: 1'b0, mosi: 1'b0, sel_n: 1'b1, clr_n: 1'b1};
         end
         sck_d      <= 1'b0;
         sel_n_d    <= 1'b1;
         sck_rise_q <= 1'b0;
         sel_fall_q <= 1'b0;
         sel_rise_q <= 1'b0;
      end else begin
         sync_q[0] <= pins;
         for (int i = 1; i < sync_stages; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         sck_d      <= pins_s.sck;
         sel_n_d    <= pins_s.sel_n;
         // Pulses land one cycle after the synchronized level
         sck_rise_q <= pins_s.sck && !sck_d;
         sel_fall_q <= !pins_s.sel_n && sel_n_d;
         sel_rise_q <= pins_s.sel_n && !sel_n_d;
      end
   end

   always_comb begin
      sampled.mosi     = pins_s.mosi;
      // Both control pins are active low
      sampled.sel      = !pins_s.sel_n;
      sampled.clr      = !pins_s.clr_n;
      sampled.sck_rise = sck_rise_q;
      sampled.sel_fall = sel_fall_q;
      sampled.sel_rise = sel_rise_q;
   end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/dac_pkg.sv
hdl/pin_sampler.sv
hdl/frame_shifter.sv
hdl/dac_frame_ctrl.sv
hdl/dac_channel_bank.sv
hdl/dac_receiver_top.sv
verification/dac_tb.sv

// ==== verification/dac_tb.sv ====
`default_nettype none

module dac_tb
   import dac_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   // Number of frames in the run sets the watchdog time
   localparam int  planned_frames = 15;
   localparam real clk_period     = 40.0;
   // Every bit takes 8 clock cycles and half again is added as margin
   localparam real watchdog_time  = planned_frames * frame_bits * 8 * clk_period * 1.5;

   logic       DAC_CS;
   logic       rst;
   pins_t      pins;
   logic       sdo;
   dac_codes_t dac_codes;
   status_t    status;
   logic       status_valid;

   // Reference model of the registers
   code_t      in_model [num_channels];
   dac_codes_t dac_model;
   // Receive register model that keeps its contents between frames
   frame_t     rx_model;

   int errors;
   int tests_passed;
   int tests_failed;

   dac_receiver_top u_dac_receiver_top (
      .DAC_CS       (DAC_CS),
      .rst          (rst),
      .pins         (pins),
      .sdo          (sdo),
      .dac_codes    (dac_codes),
      .status       (status),
      .status_valid (status_valid)
   );

   initial begin
      DAC_CS = 1'b0;
      forever #(clk_period / 2.0) DAC_CS = ~DAC_CS;
   end

   // Hard stop if the run hangs
   initial begin
      #(watchdog_time);
      $display("watchdog expired before all tests finished");
      $display("Verification failed");
      $finish;
   end

   task automatic check_status(input string name, input status_t expected,
                               input status_t actual);
      if (actual !== expected) begin
         $display("error %s: status expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_codes(input string name, input dac_codes_t expected,
                              input dac_codes_t actual);
      if (actual !== expected) begin
         $display("error %s: dac_codes expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_echo(input string name, input frame_t expected, input frame_t actual);
      if (actual !== expected) begin
         $display("error %s: sdo echo expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Register update rules of the part
   task automatic model_apply(input logic [3:0] cmd, input logic [3:0] addr, input code_t value);
      for (int ch = 0; ch < num_channels; ch++) begin
         if (addr == 4'b1111 || int'(addr) == ch) begin
            // Load comes first so write and update passes the new code on
            if (cmd == cmd_write || cmd == cmd_write_update) begin
               in_model[ch] = value;
            end
            if (cmd == cmd_update || cmd == cmd_write_update) begin
               dac_model[ch] = in_model[ch];
            end
         end
      end
   endtask

   task automatic model_clear();
      for (int ch = 0; ch < num_channels; ch++) begin
         in_model[ch] = '0;
      end
      dac_model = '0;
   endtask

   function automatic frame_t make_frame(input logic [3:0] cmd, input logic [3:0] addr,
                                         input code_t value);
      frame_t f;
      // Lead and trail are don't care and get random noise
      f.lead    = 8'($urandom());
      f.command = cmd;
      f.address = addr;
      f.value   = value;
      f.trail   = 4'($urandom());
      return f;
   endfunction

   // Low pulse on clr_n arms the part and zeroes the registers
   task automatic pulse_clear();
      @(negedge DAC_CS);
      pins.clr_n = 1'b0;
      repeat (4) @(negedge DAC_CS);
      pins.clr_n = 1'b1;
      repeat (6) @(negedge DAC_CS);
   endtask

   // Shift nbits out MSB first and wait for the status pulse
   task automatic send_frame(input string name, input logic [63:0] bits, input int nbits,
                             output status_t got, output logic [63:0] echo);
      int  wait_cycles;
      logic seen;
      echo = '0;
      got  = '0;
      seen = 1'b0;
      @(negedge DAC_CS);
      pins.sel_n = 1'b0;
      pins.sck   = 1'b0;
      for (int i = nbits - 1; i >= 0; i--) begin
         pins.mosi = bits[i];
         repeat (4) @(negedge DAC_CS);
         // Echo bit is sampled just as sck rises
         echo      = {echo[62:0], sdo};
         pins.sck  = 1'b1;
         rx_model  = frame_t'({rx_model[frame_bits-2:0], bits[i]});
         repeat (4) @(negedge DAC_CS);
         pins.sck  = 1'b0;
      end
      repeat (4) @(negedge DAC_CS);
      pins.sel_n = 1'b1;
      wait_cycles = 0;
      while (!seen && wait_cycles < 20) begin
         @(negedge DAC_CS);
         wait_cycles++;
         if (status_valid) begin
            seen = 1'b1;
            got  = status;
         end
      end
      if (!seen) begin
         $display("%s: no status_valid pulse within 20 cycles after the frame", name);
         errors++;
      end else begin
         // Status lasts one cycle and the bank update shows on the next one
         @(negedge DAC_CS);
         if (status_valid) begin
            $display("%s: status_valid stayed high for more than one cycle", name);
            errors++;
         end
      end
   endtask

   // Send raw bits and check the status and the codes against the model
   task automatic send_raw(input string name, input logic [63:0] bits, input int nbits,
                           input frame_err_e exp_err, output frame_t echo);
      status_t     got;
      status_t     expected;
      logic [63:0] echo_bits;
      send_frame(name, bits, nbits, got, echo_bits);
      echo     = frame_t'(echo_bits[frame_bits-1:0]);
      // Status carries the received fields for any verdict
      expected = '{err: exp_err, command: rx_model.command, address: rx_model.address};
      check_status(name, expected, got);
      if (exp_err == err_none) begin
         model_apply(rx_model.command, rx_model.address, rx_model.value);
      end
      check_codes(name, dac_model, dac_codes);
   endtask

   task automatic send_command(input string name, input logic [3:0] cmd,
                               input logic [3:0] addr, input code_t value,
                               input frame_err_e exp_err, output frame_t echo);
      frame_t f;
      f = make_frame(cmd, addr, value);
      send_raw(name, 64'(f), frame_bits, exp_err, echo);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("test %s passed", name);
         tests_passed++;
      end else begin
         $display("test %s failed", name);
         tests_failed++;
      end
   endtask

   task automatic test_not_armed();
      int     start;
      frame_t echo;
      start = errors;
      send_command("not_armed", cmd_write_update, 4'd0, code_t'($urandom()),
                   err_not_armed, echo);
      finish_test("not_armed", start);
   endtask

   task automatic test_write_update_each();
      int     start;
      frame_t echo;
      start = errors;
      pulse_clear();
      model_clear();
      for (int ch = 0; ch < num_channels; ch++) begin
         send_command("write_update_each", cmd_write_update, 4'(ch), code_t'($urandom()),
                      err_none, echo);
      end
      finish_test("write_update_each", start);
   endtask

   task automatic test_write_then_update();
      int     start;
      frame_t echo;
      start = errors;
      // Write alone leaves the outputs alone
      send_command("write_then_update", cmd_write, 4'd1, code_t'($urandom()), err_none, echo);
      // Update ignores the value field and passes the input register on
      send_command("write_then_update", cmd_update, 4'd1, code_t'($urandom()), err_none, echo);
      send_command("write_then_update", cmd_write_update, 4'b1111, code_t'($urandom()),
                   err_none, echo);
      finish_test("write_then_update", start);
   endtask

   task automatic test_bad_length();
      int     start;
      frame_t f;
      frame_t echo;
      start = errors;
      f = make_frame(cmd_write_update, 4'd2, code_t'($urandom()));
      // One bit missing
      send_raw("bad_length", 64'(f) >> 1, frame_bits - 1, err_short, echo);
      f = make_frame(cmd_write_update, 4'd3, code_t'($urandom()));
      // Two extra leading bits
      send_raw("bad_length", 64'({2'b11, f}), frame_bits + 2, err_long, echo);
      finish_test("bad_length", start);
   endtask

   task automatic test_bad_field();
      int     start;
      frame_t echo;
      start = errors;
      send_command("bad_field", 4'b0101, 4'd0, code_t'($urandom()), err_bad_cmd, echo);
      send_command("bad_field", cmd_write_update, 4'b0110, code_t'($urandom()),
                   err_bad_addr, echo);
      finish_test("bad_field", start);
   endtask

   task automatic test_echo_and_clear();
      int     start;
      frame_t prev;
      frame_t echo;
      start = errors;
      send_command("echo_and_clear", cmd_write_update, 4'd2, code_t'($urandom()),
                   err_none, echo);
      prev = rx_model;
      // Next frame replays the one before on sdo
      send_command("echo_and_clear", cmd_nop, 4'd0, code_t'($urandom()), err_none, echo);
      check_echo("echo_and_clear", prev, echo);
      pulse_clear();
      model_clear();
      check_codes("echo_and_clear", dac_model, dac_codes);
      send_command("echo_and_clear", cmd_write_update, 4'd3, code_t'($urandom()),
                   err_none, echo);
      finish_test("echo_and_clear", start);
   endtask

   initial begin
      void'($urandom(32'h688f));
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      rx_model     = '0;
      model_clear();
      // Idle pins with frame select and clear inactive
      pins = '{sck: 1'b0, mosi: 1'b0, sel_n: 1'b1, clr_n: 1'b1};
      rst  = 1'b1;
      repeat (10) @(negedge DAC_CS);
      rst = 1'b0;
      repeat (4) @(negedge DAC_CS);

      test_not_armed();
      test_write_update_each();
      test_write_then_update();
      test_bad_length();
      test_bad_field();
      test_echo_and_clear();

      $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
